// ==== core_pkg.sv ====
package core_pkg;

    localparam int XLEN        = 32;
    localparam int RAM_WORDS   = 256;
    localparam int RAM_LATENCY = 2;   // pop to response pulse
    localparam int QUEUE_DEPTH = 2;

    // counter and pointer widths
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int RAM_CNT_W   = $clog2(RAM_LATENCY + 1);

    typedef logic [31:0]     addr_t;
    typedef logic [XLEN-1:0] uintx_t;
    typedef logic [7:0]      word_index_t;
    typedef logic [3:0]      byte_mask_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE,
        MEM_ATOMIC
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    typedef enum logic {
        OP_SIGNED,
        OP_UNSIGNED
    } sign_e;

    typedef enum logic [3:0] {
        AMO_LR,
        AMO_SC,
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX
    } amo_op_e;

    // memory stage FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_RVALID,
        WAIT_WVALID
    } stage_state_e;

    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        sign_e     sign;   // load extension, min/max compare
        amo_op_e   amo;
    } mem_ctrl_t;

    typedef struct packed {
        logic       wen;
        addr_t      addr;
        uintx_t     wdata;
        byte_mask_t wmask;
    } dreq_t;

    typedef struct packed {
        uintx_t rdata;
    } dresp_t;

endpackage

// ==== mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  core_pkg::mem_ctrl_t ctrl,
    input  core_pkg::addr_t     addr,
    input  core_pkg::uintx_t    rs2_data,
    output core_pkg::uintx_t    rdata,
    output logic                is_stall,
    output logic                req_valid,
    output core_pkg::dreq_t     req,
    input  logic                req_ready,
    input  logic                resp_valid,
    input  core_pkg::dresp_t    resp
);
    import core_pkg::*;

    stage_state_e state;
    logic         done;       // result ready, retires on the next edge
    logic         wr_phase;   // current request is a write
    logic         sc_ok;
    logic         res_valid;
    addr_t        res_addr;
    uintx_t       rdata_q;
    logic         is_mem;
    logic         is_sc;
    logic         is_lr;
    logic         is_rmw;
    logic         sc_match;

    function automatic uintx_t amo_result(
        input amo_op_e op,
        input sign_e   sgn,
        input uintx_t  old,
        input uintx_t  src
    );
        logic lt;
        lt = (sgn == OP_SIGNED) ? ($signed(old) < $signed(src)) : (old < src);
        case (op)
            AMO_SWAP: amo_result = src;
            AMO_ADD:  amo_result = old + src;
            AMO_XOR:  amo_result = old ^ src;
            AMO_AND:  amo_result = old & src;
            AMO_OR:   amo_result = old | src;
            AMO_MIN:  amo_result = lt ? old : src;
            AMO_MAX:  amo_result = lt ? src : old;
            default:  amo_result = src;
        endcase
    endfunction

    // low lanes only, address bits 1:0 are ignored
    function automatic byte_mask_t size_mask(input mem_size_e size);
        case (size)
            SIZE_B:  size_mask = 4'b0001;
            SIZE_H:  size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    endfunction

    function automatic uintx_t format_rdata(
        input mem_ctrl_t c,
        input uintx_t    word,
        input logic      sc_status
    );
        case (c.op)
            MEM_LOAD: begin
                case (c.size)
                    SIZE_B: begin
                        format_rdata = (c.sign == OP_SIGNED) ?
                            {{(XLEN-8){word[7]}}, word[7:0]} : {{(XLEN-8){1'b0}}, word[7:0]};
                    end
                    SIZE_H: begin
                        format_rdata = (c.sign == OP_SIGNED) ?
                            {{(XLEN-16){word[15]}}, word[15:0]} : {{(XLEN-16){1'b0}}, word[15:0]};
                    end
                    default: format_rdata = word;
                endcase
            end
            MEM_ATOMIC: begin
                if (c.amo == AMO_SC) begin
                    format_rdata = {{(XLEN-1){1'b0}}, !sc_status};  // 0 on success
                end else begin
                    format_rdata = word;   // lr and amo return the old word
                end
            end
            default: format_rdata = '0;
        endcase
    endfunction

    assign is_mem   = ctrl.op != MEM_NONE;
    assign is_sc    = ctrl.op == MEM_ATOMIC && ctrl.amo == AMO_SC;
    assign is_lr    = ctrl.op == MEM_ATOMIC && ctrl.amo == AMO_LR;
    assign is_rmw   = ctrl.op == MEM_ATOMIC && !is_sc && !is_lr;
    assign sc_match = res_valid && res_addr == addr;

    assign is_stall = valid && is_mem && (state != IDLE || !done);
    assign rdata    = format_rdata(ctrl, rdata_q, sc_ok);

    assign req_valid = state == WAIT_READY;
    assign req.wen   = wr_phase;
    assign req.addr  = addr;
    assign req.wmask = (ctrl.op == MEM_ATOMIC) ? 4'b1111 : size_mask(ctrl.size);
    assign req.wdata = is_rmw ? amo_result(ctrl.amo, ctrl.sign, rdata_q, rs2_data) : rs2_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            done      <= 1'b0;
            wr_phase  <= 1'b0;
            sc_ok     <= 1'b0;
            res_valid <= 1'b0;
        end else if (!valid || !is_mem) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (done) begin
                        done <= 1'b0;
                    end else if (is_sc) begin
                        res_valid <= 1'b0;   // cleared either way
                        sc_ok     <= sc_match;
                        wr_phase  <= 1'b1;
                        if (sc_match) begin
                            state <= WAIT_READY;
                        end else begin
                            done <= 1'b1;    // no request on failure
                        end
                    end else begin
                        if (is_lr) begin
                            res_valid <= 1'b1;
                            res_addr  <= addr;
                        end
                        wr_phase <= ctrl.op == MEM_STORE;
                        state    <= WAIT_READY;
                    end
                end
                WAIT_READY: begin
                    if (req_ready) begin
                        state <= wr_phase ? WAIT_WVALID : WAIT_RVALID;
                    end
                end
                WAIT_RVALID: begin
                    if (resp_valid) begin
                        rdata_q <= resp.rdata;
                        if (is_rmw) begin
                            // second trip writes the operation result
                            wr_phase <= 1'b1;
                            state    <= WAIT_READY;
                        end else begin
                            state <= IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                WAIT_WVALID: begin
                    if (resp_valid) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== dreq_queue.sv ====
`timescale 1ns/100ps

module dreq_queue (
    input  logic            clk,
    input  logic            reset,
    input  logic            push_valid,
    input  core_pkg::dreq_t push,
    output logic            push_ready,
    output logic            head_valid,
    output core_pkg::dreq_t head,
    input  logic            pop
);
    import core_pkg::*;

    dreq_t                  entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   push_fire;
    logic                   pop_fire;

    function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
        if (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
    endfunction

    assign push_ready = count != QUEUE_CNT_W'(QUEUE_DEPTH);  // only back-pressure
    assign head_valid = count != '0;
    assign head       = entries[rd_ptr];
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop && head_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            entries[wr_ptr] <= push;
        end
    end

endmodule

// ==== data_ram.sv ====
`timescale 1ns/100ps

module data_ram (
    input  logic             clk,
    input  logic             reset,
    input  logic             head_valid,
    input  core_pkg::dreq_t  head,
    output logic             pop,
    output logic             resp_valid,
    output core_pkg::dresp_t resp
);
    import core_pkg::*;

    uintx_t               mem [RAM_WORDS];
    logic                 busy;
    logic [RAM_CNT_W-1:0] cnt;       // cycles left until the response
    uintx_t               rdata_q;
    word_index_t          idx;

    assign idx        = head.addr[9:2];
    assign pop        = head_valid && !busy;
    assign resp_valid = busy && cnt == '0;
    assign resp.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (pop) begin
            busy <= 1'b1;
            cnt  <= RAM_CNT_W'(RAM_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;   // response cycle ends the access
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // access happens at the pop edge
    always_ff @(posedge clk) begin
        if (pop) begin
            if (head.wen) begin
                for (int i = 0; i < $bits(byte_mask_t); i++) begin
                    if (head.wmask[i]) begin
                        mem[idx][8*i +: 8] <= head.wdata[8*i +: 8];
                    end
                end
                rdata_q <= '0;   // writes answer with zero
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

endmodule

// ==== mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  core_pkg::mem_ctrl_t ctrl,
    input  core_pkg::addr_t     addr,
    input  core_pkg::uintx_t    rs2_data,
    output core_pkg::uintx_t    rdata,
    output logic                is_stall
);
    import core_pkg::*;

    logic   req_valid;
    dreq_t  req;
    logic   req_ready;
    logic   head_valid;
    dreq_t  head;
    logic   pop;
    logic   resp_valid;
    dresp_t resp;

    mem_stage u_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .ctrl       (ctrl),
        .addr       (addr),
        .rs2_data   (rs2_data),
        .rdata      (rdata),
        .is_stall   (is_stall),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    dreq_queue u_dreq_queue (
        .clk        (clk),
        .reset      (reset),
        .push_valid (req_valid),
        .push       (req),
        .push_ready (req_ready),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop)
    );

    // responses go straight back to the stage
    data_ram u_data_ram (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

// ==== mem_subsys_properties.sv ====
`timescale 1ns/100ps

module mem_subsys_properties (
    input logic            clk,
    input logic            reset,
    input logic            valid,
    input logic            is_stall,
    input logic            req_valid,
    input logic            req_ready,
    input core_pkg::dreq_t req,
    input logic            resp_valid
);

    int failures;

    initial failures = 0;

    req_held: assert property (@(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> $stable(req))
        else begin
            failures++;
            $error("req changed while req_ready was low");
        end

    resp_single: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid)
        else begin
            failures++;
            $error("resp_valid high for two cycles in a row");
        end

    stall_needs_valid: assert property (@(posedge clk) disable iff (reset)
        !valid |-> !is_stall)
        else begin
            failures++;
            $error("is_stall high while valid is low");
        end

endmodule

bind mem_stage mem_subsys_properties props0 (
    .clk        (clk),
    .reset      (reset),
    .valid      (valid),
    .is_stall   (is_stall),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid)
);

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #10 reset = 1'b0;
    end

endmodule

// ==== mem_subsys_tb.sv ====
`timescale 1ns/100ps

module mem_subsys_tb;
    import core_pkg::*;

    logic      clk;
    logic      reset;
    logic      valid;
    mem_ctrl_t ctrl;
    addr_t     addr;
    uintx_t    rs2_data;
    uintx_t    rdata;
    logic      is_stall;

    uintx_t      model [RAM_WORDS];
    logic        written [RAM_WORDS];
    logic        res_set;      // reservation as the model sees it
    addr_t       res_addr_m;
    logic [31:0] lfsr_state;
    logic        first_stall;  // is_stall at the first sample of an instruction
    logic        aborted;
    int          checks;
    int          errors;
    int          timeouts;

    tb_clock clock0 (
        .clk   (clk),
        .reset (reset)
    );

    mem_subsys_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .valid    (valid),
        .ctrl     (ctrl),
        .addr     (addr),
        .rs2_data (rs2_data),
        .rdata    (rdata),
        .is_stall (is_stall)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic uintx_t random_bits(input int n);
        uintx_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic addr_t random_addr();
        uintx_t r;
        r = random_bits(8);
        return {22'b0, r[7:0], 2'b00};
    endfunction

    function automatic mem_ctrl_t make_ctrl(
        input mem_op_e   op,
        input mem_size_e size,
        input sign_e     sgn,
        input amo_op_e   amo
    );
        mem_ctrl_t c;
        c.op   = op;
        c.size = size;
        c.sign = sgn;
        c.amo  = amo;
        return c;
    endfunction

    function automatic uintx_t extend_load(input uintx_t word, input mem_size_e size,
                                           input sign_e sgn);
        case (size)
            SIZE_B:  return (sgn == OP_SIGNED) ? uintx_t'($signed(word << 24) >>> 24)
                                               : (word & 32'h0000_00ff);
            SIZE_H:  return (sgn == OP_SIGNED) ? uintx_t'($signed(word << 16) >>> 16)
                                               : (word & 32'h0000_ffff);
            default: return word;
        endcase
    endfunction

    function automatic uintx_t amo_expected(input amo_op_e op, input sign_e sgn,
                                            input uintx_t old, input uintx_t src);
        uintx_t bias;
        logic   old_below;
        bias      = (sgn == OP_SIGNED) ? 32'h8000_0000 : 32'h0;  // flip sign bit for signed
        old_below = (old ^ bias) < (src ^ bias);
        case (op)
            AMO_SWAP: return src;
            AMO_ADD:  return old + src;
            AMO_XOR:  return old ^ src;
            AMO_AND:  return old & src;
            AMO_OR:   return old | src;
            AMO_MIN:  return old_below ? old : src;
            AMO_MAX:  return old_below ? src : old;
            default:  return old;
        endcase
    endfunction

    task automatic check_value(input string name, input uintx_t got, input uintx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // present one instruction and wait for is_stall to drop
    task automatic run_op(input mem_ctrl_t c, input addr_t a, input uintx_t d,
                          output uintx_t result);
        int cycles;
        result = '0;
        if (aborted) begin
            return;
        end
        @(posedge clk);
        #10;
        valid    = 1'b1;
        ctrl     = c;
        addr     = a;
        rs2_data = d;
        cycles   = 0;
        @(negedge clk);
        first_stall = is_stall;
        while (is_stall && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (is_stall) begin
            $display("timeout: instruction at address %h never finished", a);
            timeouts++;
            aborted = 1'b1;
        end else begin
            result = rdata;
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        #10;
        valid   = 1'b0;
        ctrl.op = MEM_NONE;
    endtask

    task automatic write_mem(input mem_size_e size, input addr_t a, input uintx_t d);
        uintx_t      unused;
        word_index_t w;
        w = a[9:2];
        run_op(make_ctrl(MEM_STORE, size, OP_UNSIGNED, AMO_LR), a, d, unused);
        case (size)
            SIZE_B:  model[w][7:0]  = d[7:0];
            SIZE_H:  model[w][15:0] = d[15:0];
            default: model[w]       = d;
        endcase
        written[w] = 1'b1;
    endtask

    task automatic read_check(input mem_size_e size, input sign_e sgn, input addr_t a);
        uintx_t got;
        run_op(make_ctrl(MEM_LOAD, size, sgn, AMO_LR), a, random_bits(32), got);
        check_value("rdata", got, extend_load(model[a[9:2]], size, sgn));
    endtask

    task automatic reserve(input addr_t a);
        uintx_t got;
        run_op(make_ctrl(MEM_ATOMIC, SIZE_W, OP_SIGNED, AMO_LR), a, '0, got);
        check_value("rdata", got, model[a[9:2]]);
        res_set    = 1'b1;
        res_addr_m = a;
    endtask

    task automatic cond_store(input addr_t a, input uintx_t d);
        uintx_t got;
        logic   ok;
        ok = res_set && res_addr_m == a;
        run_op(make_ctrl(MEM_ATOMIC, SIZE_W, OP_SIGNED, AMO_SC), a, d, got);
        check_value("rdata", got, ok ? 32'd0 : 32'd1);
        if (ok) begin
            model[a[9:2]] = d;
        end
        res_set = 1'b0;   // gone either way
    endtask

    task automatic atomic_op(input amo_op_e op, input sign_e sgn, input addr_t a,
                             input uintx_t d);
        uintx_t got;
        uintx_t old;
        old = model[a[9:2]];
        run_op(make_ctrl(MEM_ATOMIC, SIZE_W, sgn, op), a, d, got);
        check_value("rdata", got, old);
        model[a[9:2]] = amo_expected(op, sgn, old, d);
    endtask

    task automatic nop_op();
        uintx_t unused;
        run_op(make_ctrl(MEM_NONE, SIZE_W, OP_SIGNED, AMO_LR), random_addr(), '0, unused);
        check_value("is_stall", uintx_t'(first_stall), '0);
    endtask

    task automatic word_store_load();
        addr_t addrs [8];
        write_mem(SIZE_W, 32'h0000_0040, 32'hdead_beef);
        read_check(SIZE_W, OP_UNSIGNED, 32'h0000_0040);
        for (int i = 0; i < 8; i++) begin
            addrs[i] = random_addr();
            write_mem(SIZE_W, addrs[i], random_bits(32));
        end
        for (int i = 0; i < 8; i++) begin
            read_check(SIZE_W, OP_UNSIGNED, addrs[i]);
        end
        go_idle();
    endtask

    task automatic sub_word_lanes();
        addr_t a;
        a = random_addr();
        write_mem(SIZE_W, a, random_bits(32));
        write_mem(SIZE_B, a, random_bits(32) | 32'h80);   // negative byte
        read_check(SIZE_B, OP_SIGNED, a);
        read_check(SIZE_B, OP_UNSIGNED, a);
        read_check(SIZE_W, OP_UNSIGNED, a);
        write_mem(SIZE_H, a, random_bits(32) & ~32'h8000);
        read_check(SIZE_H, OP_SIGNED, a);
        read_check(SIZE_H, OP_UNSIGNED, a);
        write_mem(SIZE_H, a, random_bits(32) | 32'h8000);
        read_check(SIZE_H, OP_SIGNED, a);
        read_check(SIZE_H, OP_UNSIGNED, a);
        read_check(SIZE_W, OP_UNSIGNED, a);
        write_mem(SIZE_B, a, random_bits(32) & ~32'h80);
        read_check(SIZE_B, OP_SIGNED, a);
        read_check(SIZE_W, OP_SIGNED, a);
        go_idle();
    endtask

    task automatic lr_sc_pairs();
        addr_t a;
        addr_t b;
        a = 32'h0000_0100;
        b = 32'h0000_0104;
        write_mem(SIZE_W, a, random_bits(32));
        write_mem(SIZE_W, b, random_bits(32));
        reserve(a);
        cond_store(a, random_bits(32));
        read_check(SIZE_W, OP_UNSIGNED, a);
        cond_store(a, random_bits(32));   // reservation already used
        read_check(SIZE_W, OP_UNSIGNED, a);
        reserve(a);
        cond_store(b, random_bits(32));
        read_check(SIZE_W, OP_UNSIGNED, b);
        go_idle();
    endtask

    // min or max with operands of opposite sign, both orders
    task automatic min_max_pair(input amo_op_e op, input sign_e sgn, input addr_t a);
        uintx_t pos;
        uintx_t neg;
        pos = random_bits(32) & 32'h7fff_ffff;
        neg = random_bits(32) | 32'h8000_0000;
        write_mem(SIZE_W, a, pos);
        atomic_op(op, sgn, a, neg);
        read_check(SIZE_W, OP_UNSIGNED, a);
        write_mem(SIZE_W, a, neg);
        atomic_op(op, sgn, a, pos);
        read_check(SIZE_W, OP_UNSIGNED, a);
    endtask

    task automatic amo_ops();
        addr_t a;
        a = random_addr();
        write_mem(SIZE_W, a, random_bits(32));
        atomic_op(AMO_SWAP, OP_SIGNED, a, random_bits(32));
        read_check(SIZE_W, OP_UNSIGNED, a);
        atomic_op(AMO_ADD, OP_SIGNED, a, random_bits(32));
        read_check(SIZE_W, OP_UNSIGNED, a);
        atomic_op(AMO_XOR, OP_SIGNED, a, random_bits(32));
        read_check(SIZE_W, OP_UNSIGNED, a);
        atomic_op(AMO_AND, OP_SIGNED, a, random_bits(32));
        read_check(SIZE_W, OP_UNSIGNED, a);
        atomic_op(AMO_OR, OP_SIGNED, a, random_bits(32));
        read_check(SIZE_W, OP_UNSIGNED, a);
        min_max_pair(AMO_MIN, OP_SIGNED, a);
        min_max_pair(AMO_MAX, OP_SIGNED, a);
        min_max_pair(AMO_MIN, OP_UNSIGNED, a);
        min_max_pair(AMO_MAX, OP_UNSIGNED, a);
        go_idle();
    endtask

    task automatic back_to_back();
        addr_t a;
        addr_t b;
        a = random_addr();
        b = random_addr();
        write_mem(SIZE_W, a, random_bits(32));
        nop_op();
        write_mem(SIZE_W, b, random_bits(32));
        // a repeated add shows up in memory if it ran twice
        atomic_op(AMO_ADD, OP_SIGNED, a, 32'd1);
        atomic_op(AMO_ADD, OP_SIGNED, a, 32'd1);
        nop_op();
        nop_op();
        write_mem(SIZE_B, b, random_bits(32));
        nop_op();
        for (int i = 0; i < RAM_WORDS; i++) begin
            if (written[i]) begin
                read_check(SIZE_W, OP_UNSIGNED, addr_t'(i) << 2);
            end
        end
        go_idle();
    endtask

    initial begin
        int cycles;
        int assert_fails;
        valid    = 1'b0;
        ctrl     = make_ctrl(MEM_NONE, SIZE_W, OP_SIGNED, AMO_LR);
        addr     = '0;
        rs2_data = '0;
        lfsr_state  = 32'hc4d1_8de9;
        res_set     = 1'b0;
        res_addr_m  = '0;
        first_stall = 1'b0;
        aborted     = 1'b0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model[i]   = '0;
            written[i] = 1'b0;
        end

        cycles = 0;
        while (reset !== 1'b0 && cycles < 40) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("timeout: reset was never released");
            timeouts++;
            aborted = 1'b1;
        end

        word_store_load();
        sub_word_lanes();
        lr_sc_pairs();
        amo_ops();
        back_to_back();

        assert_fails = dut0.u_mem_stage.props0.failures;
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
core_pkg.sv
mem_stage.sv
dreq_queue.sv
data_ram.sv
mem_subsys_top.sv
mem_subsys_properties.sv
tb_clock.sv
mem_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS RUNFLAGS"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not complete"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
